// ==== Makefile ====
TOP := tb_cache_mem_adapter
LOG := sim.log

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	  -f cache_mem_adapter.f -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f cache_mem_adapter.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

// ==== cache_mem_adapter.f ====
verilog/adapter_pkg.sv
verilog/id_fifo.sv
verilog/req_arbiter.sv
verilog/beat_counter.sv
verilog/line_assembler.sv
verilog/rtrn_ctrl.sv
verilog/cache_mem_adapter.sv
dv/tb_cache_mem_adapter.sv

// ==== dv/tb_cache_mem_adapter.sv ====
`timescale 1ns/1ns

module tb_cache_mem_adapter;

  localparam int CLK_PERIOD = 10;
  localparam int N_IFILL    = 40;
  localparam int N_DREQ     = 40;
  localparam int N_TXN      = N_IFILL + N_DREQ;

  typedef struct packed {
    adapter_pkg::tid_t tid;
    logic [2:0]        beats;
  } burst_t;

  logic                      clk_i, rst_ni;
  logic                      icache_req_i, icache_ack_o, icache_rtrn_vld_o;
  adapter_pkg::icache_req_t  icache_req_data_i;
  adapter_pkg::icache_rtrn_t icache_rtrn_o;
  logic                      dcache_req_i, dcache_ack_o, dcache_rtrn_vld_o;
  adapter_pkg::dcache_req_t  dcache_req_data_i;
  adapter_pkg::dcache_rtrn_t dcache_rtrn_o;
  logic                      mem_req_valid_o, mem_gnt_i;
  adapter_pkg::mem_req_t     mem_req_o;
  logic                      mem_rd_valid_i, mem_rd_ready_o;
  adapter_pkg::mem_rd_t      mem_rd_i;
  logic                      mem_b_valid_i, mem_b_ready_o;

  int seed = 55;
  int seed_i, seed_d, seed_m;
  int errors = 0;
  int rtrn_cnt = 0;
  int i_occ = 0;
  int d_occ = 0;
  logic i_due = 1'b0;
  logic d_due = 1'b0;
  logic b_taken = 1'b0;
  logic prev_valid = 1'b0;
  logic prev_gnt = 1'b0;
  adapter_pkg::mem_req_t prev_req;

  // reference model queues
  adapter_pkg::icache_req_t  i_req_q[$];
  adapter_pkg::dcache_req_t  d_req_q[$];
  burst_t                    i_rd_q[$], d_rd_q[$];
  adapter_pkg::tid_t         wr_tid_q[$];
  adapter_pkg::icache_rtrn_t exp_i_q[$];
  adapter_pkg::dcache_rtrn_t exp_d_q[$];

  cache_mem_adapter dut (.*);

  initial begin : clock
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////
  // helpers

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("** Failure at %0t ns: %s", $time, what);
  endtask

  function automatic logic [63:0] rand_word(inout int s);
    logic [63:0] w;
    w[63:32] = $random(s);
    w[31:0]  = $random(s);
    return w;
  endfunction

  // lanes of a 2**size byte access aligned down to its own size
  function automatic logic [7:0] expected_be(input logic [2:0] offs, input logic [1:0] size);
    int         nbytes;
    int         first;
    logic [7:0] be;
    nbytes = 1 << size;
    first  = offs & ~(nbytes - 1);
    for (int b = 0; b < 8; b++) begin
      be[b] = (b >= first) && (b < first + nbytes);
    end
    return be;
  endfunction

  ////////////////////
  // cache drivers

  task automatic drive_icache(input int n);
    adapter_pkg::icache_req_t r;
    logic [63:0]              rnd;
    for (int k = 0; k < n; k++) begin
      rnd     = rand_word(seed_i);
      r.paddr = rnd[adapter_pkg::PLEN-1:0];
      r.nc    = ($random(seed_i) & 3) == 0;
      r.tid   = 2'($random(seed_i));
      icache_req_data_i = r;
      icache_req_i      = 1'b1;
      // hold until the adapter acks
      do begin
        @(negedge clk_i);
      end while (!icache_ack_o);
      @(posedge clk_i);
      #1;
      icache_req_i = 1'b0;
      repeat ($random(seed_i) & 3) begin
        @(posedge clk_i);
        #1;
      end
    end
  endtask

  task automatic drive_dcache(input int n);
    adapter_pkg::dcache_req_t r;
    logic [63:0]              rnd;
    for (int k = 0; k < n; k++) begin
      rnd     = rand_word(seed_d);
      r.paddr = rnd[adapter_pkg::PLEN-1:0];
      r.data  = rand_word(seed_d);
      r.tid   = 2'($random(seed_d));
      if (($random(seed_d) & 3) < 2) begin
        r.rtype = adapter_pkg::DREQ_STORE;
        r.size  = {1'b0, 2'($random(seed_d))};
      end else begin
        r.rtype = adapter_pkg::DREQ_LOAD;
        // bit 2 asks for the whole line
        r.size  = ($random(seed_d) & 1) ? 3'b111 : 3'b011;
      end
      dcache_req_data_i = r;
      dcache_req_i      = 1'b1;
      do begin
        @(negedge clk_i);
      end while (!dcache_ack_o);
      @(posedge clk_i);
      #1;
      dcache_req_i = 1'b0;
      repeat ($random(seed_d) & 3) begin
        @(posedge clk_i);
        #1;
      end
    end
  endtask

  ////////////////////
  // checks at the falling edge

  task automatic check_returns();
    adapter_pkg::icache_rtrn_t exp_i;
    adapter_pkg::dcache_rtrn_t exp_d;
    logic                      b_acc;
    check_value("icache_rtrn_vld_o", icache_rtrn_vld_o, i_due);
    check_value("dcache_rtrn_vld_o", dcache_rtrn_vld_o, d_due);
    if (icache_rtrn_vld_o) begin
      rtrn_cnt++;
      assert (exp_i_q.size() > 0) else report_failure("icache return with no fill outstanding");
      if (exp_i_q.size() > 0) begin
        exp_i = exp_i_q.pop_front();
        check_value("icache_rtrn_o.tid", icache_rtrn_o.tid, exp_i.tid);
        check_value("icache_rtrn_o.data", icache_rtrn_o.data, exp_i.data);
      end
    end
    if (dcache_rtrn_vld_o) begin
      rtrn_cnt++;
      assert (exp_d_q.size() > 0) else report_failure("dcache return with nothing outstanding");
      if (exp_d_q.size() > 0) begin
        exp_d = exp_d_q.pop_front();
        check_value("dcache_rtrn_o.rtype", dcache_rtrn_o.rtype, exp_d.rtype);
        check_value("dcache_rtrn_o.tid", dcache_rtrn_o.tid, exp_d.tid);
        if (exp_d.rtype == adapter_pkg::DRTRN_LOAD_ACK) begin
          check_value("dcache_rtrn_o.data", dcache_rtrn_o.data, exp_d.data);
        end
      end
    end
    check_value("mem_rd_ready_o", mem_rd_ready_o, 1'b1);
    check_value("mem_b_ready_o", mem_b_ready_o, !mem_rd_valid_i);
    // returns due one cycle after the coming edge
    b_acc = mem_b_valid_i && mem_b_ready_o;
    i_due = mem_rd_valid_i && mem_rd_i.id == adapter_pkg::ICACHE_CHAN && mem_rd_i.last;
    d_due = (mem_rd_valid_i && mem_rd_i.id == adapter_pkg::DCACHE_CHAN && mem_rd_i.last) ||
            b_acc;
    if (b_acc) begin
      exp_d       = '0;
      exp_d.rtype = adapter_pkg::DRTRN_STORE_ACK;
      exp_d.tid   = wr_tid_q.pop_front();
      exp_d_q.push_back(exp_d);
      b_taken = 1'b1;
    end
  endtask

  task automatic check_requests();
    adapter_pkg::mem_req_t    exp_r;
    adapter_pkg::icache_req_t ir;
    adapter_pkg::dcache_req_t dr;
    burst_t                   rd_burst;
    logic                     have_exp;
    check_value("icache_ack_o", icache_ack_o,
                icache_req_i && (i_occ < adapter_pkg::REQ_DEPTH));
    check_value("dcache_ack_o", dcache_ack_o,
                dcache_req_i && (d_occ < adapter_pkg::REQ_DEPTH));
    if (prev_valid && !prev_gnt) begin
      check_value("mem_req_valid_o", mem_req_valid_o, 1'b1);
      check_value("mem_req_o", mem_req_o, prev_req);
    end
    if (mem_req_valid_o) begin
      assert (i_occ + d_occ > 0)
        else report_failure("memory request with no cache request pending");
    end
    have_exp = 1'b0;
    exp_r    = '0;
    if (mem_req_valid_o && mem_gnt_i && mem_req_o.id == adapter_pkg::ICACHE_CHAN) begin
      assert (i_req_q.size() > 0) else report_failure("icache request granted but never acked");
      if (i_req_q.size() > 0) begin
        ir         = i_req_q.pop_front();
        i_occ--;
        have_exp   = 1'b1;
        exp_r.addr = ir.paddr;
        exp_r.size = adapter_pkg::SIZE_WORD;
        exp_r.blen = ir.nc ? '0 : adapter_pkg::blen_t'(adapter_pkg::ILINE_WORDS - 1);
        rd_burst.tid   = ir.tid;
        rd_burst.beats = 3'(exp_r.blen) + 3'd1;
        i_rd_q.push_back(rd_burst);
      end
    end else if (mem_req_valid_o && mem_gnt_i) begin
      assert (d_req_q.size() > 0) else report_failure("dcache request granted but never acked");
      if (d_req_q.size() > 0) begin
        dr         = d_req_q.pop_front();
        d_occ--;
        have_exp   = 1'b1;
        exp_r.addr = dr.paddr;
        exp_r.size = dr.size[1:0];
        if (dr.rtype == adapter_pkg::DREQ_STORE) begin
          exp_r.we    = 1'b1;
          exp_r.wdata = dr.data;
          exp_r.be    = expected_be(dr.paddr[2:0], dr.size[1:0]);
          wr_tid_q.push_back(dr.tid);
        end else begin
          exp_r.blen = dr.size[2] ? adapter_pkg::blen_t'(adapter_pkg::DLINE_WORDS - 1) : '0;
          rd_burst.tid   = dr.tid;
          rd_burst.beats = 3'(exp_r.blen) + 3'd1;
          d_rd_q.push_back(rd_burst);
        end
      end
    end
    if (have_exp) begin
      check_value("mem_req_o.we", mem_req_o.we, exp_r.we);
      check_value("mem_req_o.addr", mem_req_o.addr, exp_r.addr);
      check_value("mem_req_o.size", mem_req_o.size, exp_r.size);
      check_value("mem_req_o.blen", mem_req_o.blen, exp_r.blen);
      if (exp_r.we) begin
        check_value("mem_req_o.wdata", mem_req_o.wdata, exp_r.wdata);
        check_value("mem_req_o.be", mem_req_o.be, exp_r.be);
      end
    end
    prev_valid = mem_req_valid_o;
    prev_gnt   = mem_gnt_i;
    prev_req   = mem_req_o;
    if (icache_ack_o) begin
      i_req_q.push_back(icache_req_data_i);
      i_occ++;
    end
    if (dcache_ack_o) begin
      d_req_q.push_back(dcache_req_data_i);
      d_occ++;
    end
  endtask

  always @(negedge clk_i) begin : monitor
    if (rst_ni) begin
      check_returns();
      check_requests();
    end
  end

  ////////////////////
  // memory responder

  initial begin : mem_responder
    burst_t               cur;
    logic                 cur_ch;
    int                   beats_left;
    int                   beat_idx;
    adapter_pkg::mem_rd_t rd;
    logic [adapter_pkg::ILINE_WORDS-1:0][adapter_pkg::WORD_W-1:0] line;
    adapter_pkg::icache_rtrn_t exp_i;
    adapter_pkg::dcache_rtrn_t exp_d;
    beats_left = 0;
    beat_idx   = 0;
    wait (rst_ni);
    forever begin
      @(posedge clk_i);
      #1;
      mem_gnt_i = ($random(seed_m) & 7) < 3;
      if (b_taken) begin
        mem_b_valid_i = 1'b0;
        b_taken       = 1'b0;
      end
      if (!mem_b_valid_i && wr_tid_q.size() > 0 && ($random(seed_m) & 3) == 0) begin
        mem_b_valid_i = 1'b1;
      end
      mem_rd_valid_i = 1'b0;
      // one burst at a time and in order per channel
      if (beats_left == 0 && ($random(seed_m) & 1) == 1) begin
        if (i_rd_q.size() > 0 && (d_rd_q.size() == 0 || ($random(seed_m) & 1) == 1)) begin
          cur        = i_rd_q.pop_front();
          cur_ch     = adapter_pkg::ICACHE_CHAN;
          beats_left = cur.beats;
        end else if (d_rd_q.size() > 0) begin
          cur        = d_rd_q.pop_front();
          cur_ch     = adapter_pkg::DCACHE_CHAN;
          beats_left = cur.beats;
        end
        beat_idx = 0;
        line     = '0;
      end
      if (beats_left > 0 && ($random(seed_m) & 3) != 0) begin
        rd.data        = rand_word(seed_m);
        rd.id          = cur_ch;
        rd.last        = beats_left == 1;
        mem_rd_i       = rd;
        mem_rd_valid_i = 1'b1;
        line[beat_idx] = rd.data;
        beat_idx++;
        beats_left--;
        if (rd.last && cur_ch == adapter_pkg::ICACHE_CHAN) begin
          exp_i.tid  = cur.tid;
          exp_i.data = line;
          exp_i_q.push_back(exp_i);
        end else if (rd.last) begin
          exp_d.rtype = adapter_pkg::DRTRN_LOAD_ACK;
          exp_d.tid   = cur.tid;
          exp_d.data  = line[adapter_pkg::DLINE_WORDS-1:0];
          exp_d_q.push_back(exp_d);
        end
      end
    end
  end

  ////////////////////
  // run control

  initial begin : watchdog
    #(200 * N_TXN * CLK_PERIOD);
    errors++;
    $display("timeout: only %0d of %0d returns arrived", rtrn_cnt, N_TXN);
    $display("transactions %0d, returns %0d, errors %0d", N_TXN, rtrn_cnt, errors);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : main
    seed_i            = seed;
    seed_d            = seed + 1;
    seed_m            = seed + 2;
    rst_ni            = 1'b0;
    icache_req_i      = 1'b0;
    icache_req_data_i = '0;
    dcache_req_i      = 1'b0;
    dcache_req_data_i = '0;
    mem_gnt_i         = 1'b0;
    mem_rd_valid_i    = 1'b0;
    mem_rd_i          = '0;
    mem_b_valid_i     = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    fork
      drive_icache(N_IFILL);
      drive_dcache(N_DREQ);
    join
    wait (rtrn_cnt >= N_TXN);
    repeat (10) @(posedge clk_i);
    assert (i_req_q.size() + d_req_q.size() + i_rd_q.size() + d_rd_q.size() +
            wr_tid_q.size() + exp_i_q.size() + exp_d_q.size() == 0)
      else report_failure("transactions still outstanding at the end of the run");
    $display("transactions %0d, returns %0d, errors %0d", N_TXN, rtrn_cnt, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog/adapter_pkg.sv ====
package adapter_pkg;

  ////////////////////
  // sizes

  localparam int unsigned PLEN        = 40;
  localparam int unsigned WORD_W      = 64;
  localparam int unsigned TID_W       = 2;
  localparam int unsigned ILINE_WORDS = 4;
  localparam int unsigned DLINE_WORDS = 2;
  localparam int unsigned BLEN_W      = 2;
  localparam int unsigned REQ_DEPTH   = 2;
  localparam int unsigned META_DEPTH  = 4;

  // memory channel ids
  localparam logic ICACHE_CHAN = 1'b0;
  localparam logic DCACHE_CHAN = 1'b1;

  // 8 byte access
  localparam logic [1:0] SIZE_WORD = 2'd3;

  typedef logic [TID_W-1:0]  tid_t;
  typedef logic [BLEN_W-1:0] blen_t;
  typedef logic [WORD_W-1:0] word_t;

  ////////////////////
  // encodings

  typedef enum logic {
    DREQ_LOAD,
    DREQ_STORE
  } dreq_e;

  typedef enum logic {
    DRTRN_LOAD_ACK,
    DRTRN_STORE_ACK
  } drtrn_e;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_HOLD_I,
    ARB_HOLD_D
  } arb_state_e;

  ////////////////////
  // packets

  typedef struct packed {
    logic [PLEN-1:0] paddr;
    logic            nc;
    tid_t            tid;
  } icache_req_t;

  // size bit 2 set requests a full line
  typedef struct packed {
    dreq_e           rtype;
    logic [PLEN-1:0] paddr;
    logic [2:0]      size;
    word_t           data;
    tid_t            tid;
  } dcache_req_t;

  typedef struct packed {
    logic            we;
    logic [PLEN-1:0] addr;
    logic [1:0]      size;
    blen_t           blen;
    logic            id;
    word_t           wdata;
    logic [7:0]      be;
  } mem_req_t;

  typedef struct packed {
    word_t data;
    logic  id;
    logic  last;
  } mem_rd_t;

  typedef struct packed {
    tid_t                         tid;
    logic [ILINE_WORDS-1:0][WORD_W-1:0] data;
  } icache_rtrn_t;

  typedef struct packed {
    drtrn_e                             rtype;
    tid_t                               tid;
    logic [DLINE_WORDS-1:0][WORD_W-1:0] data;
  } dcache_rtrn_t;

endpackage

// ==== verilog/beat_counter.sv ====
`timescale 1ns/1ns

module beat_counter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   beat_i,
  input  logic                   last_i,
  output adapter_pkg::blen_t     idx_o
);

  adapter_pkg::blen_t idx_q;

  // slot of the next beat returns to zero once a burst ends
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
    if (!rst_ni) begin
      idx_q <= '0;
    end else if (beat_i) begin
      if (last_i) begin
        idx_q <= '0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  assign idx_o = idx_q;

endmodule

// ==== verilog/cache_mem_adapter.sv ====
`timescale 1ns/1ns

module cache_mem_adapter (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // icache
  input  logic                      icache_req_i,
  input  adapter_pkg::icache_req_t  icache_req_data_i,
  output logic                      icache_ack_o,
  output logic                      icache_rtrn_vld_o,
  output adapter_pkg::icache_rtrn_t icache_rtrn_o,
  // dcache
  input  logic                      dcache_req_i,
  input  adapter_pkg::dcache_req_t  dcache_req_data_i,
  output logic                      dcache_ack_o,
  output logic                      dcache_rtrn_vld_o,
  output adapter_pkg::dcache_rtrn_t dcache_rtrn_o,
  // memory
  output logic                      mem_req_valid_o,
  output adapter_pkg::mem_req_t     mem_req_o,
  input  logic                      mem_gnt_i,
  input  logic                      mem_rd_valid_i,
  input  adapter_pkg::mem_rd_t      mem_rd_i,
  output logic                      mem_rd_ready_o,
  input  logic                      mem_b_valid_i,
  output logic                      mem_b_ready_o
);

  adapter_pkg::icache_req_t ireq;
  adapter_pkg::dcache_req_t dreq;
  logic                     ireq_full, ireq_empty;
  logic                     dreq_full, dreq_empty;
  logic                     ipop, dpop;
  logic                     ird_full, drd_full, dwr_full;
  logic                     ird_pop, drd_pop, dwr_pop;
  logic                     ibeat, dbeat;
  adapter_pkg::tid_t        itid, drd_tid, dwr_tid;

  logic [adapter_pkg::ILINE_WORDS-1:0][adapter_pkg::WORD_W-1:0] iline;
  logic [adapter_pkg::DLINE_WORDS-1:0][adapter_pkg::WORD_W-1:0] dline;

  ////////////////////
  // request path

  assign icache_ack_o = icache_req_i & ~ireq_full;
  assign dcache_ack_o = dcache_req_i & ~dreq_full;

  id_fifo #(
    .dtype ( adapter_pkg::icache_req_t ),
    .DEPTH ( adapter_pkg::REQ_DEPTH    )
  ) i_ireq_fifo (
    .clk_i   ( clk_i             ),
    .rst_ni  ( rst_ni            ),
    .push_i  ( icache_ack_o      ),
    .data_i  ( icache_req_data_i ),
    .pop_i   ( ipop              ),
    .data_o  ( ireq              ),
    .full_o  ( ireq_full         ),
    .empty_o ( ireq_empty        )
  );

  id_fifo #(
    .dtype ( adapter_pkg::dcache_req_t ),
    .DEPTH ( adapter_pkg::REQ_DEPTH    )
  ) i_dreq_fifo (
    .clk_i   ( clk_i             ),
    .rst_ni  ( rst_ni            ),
    .push_i  ( dcache_ack_o      ),
    .data_i  ( dcache_req_data_i ),
    .pop_i   ( dpop              ),
    .data_o  ( dreq              ),
    .full_o  ( dreq_full         ),
    .empty_o ( dreq_empty        )
  );

  req_arbiter i_req_arbiter (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .ireq_i          ( ireq            ),
    .ireq_empty_i    ( ireq_empty      ),
    .dreq_i          ( dreq            ),
    .dreq_empty_i    ( dreq_empty      ),
    .ird_full_i      ( ird_full        ),
    .drd_full_i      ( drd_full        ),
    .dwr_full_i      ( dwr_full        ),
    .mem_gnt_i       ( mem_gnt_i       ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_o       ( mem_req_o       ),
    .ipop_o          ( ipop            ),
    .dpop_o          ( dpop            )
  );

  ////////////////////
  // tid fifos

  id_fifo #(
    .dtype ( adapter_pkg::tid_t      ),
    .DEPTH ( adapter_pkg::META_DEPTH )
  ) i_ird_fifo (
    .clk_i   ( clk_i    ),
    .rst_ni  ( rst_ni   ),
    .push_i  ( ipop     ),
    .data_i  ( ireq.tid ),
    .pop_i   ( ird_pop  ),
    .data_o  ( itid     ),
    .full_o  ( ird_full ),
    .empty_o (          )
  );

  // data side tid goes to the read or write fifo by the request's write flag
  id_fifo #(
    .dtype ( adapter_pkg::tid_t      ),
    .DEPTH ( adapter_pkg::META_DEPTH )
  ) i_drd_fifo (
    .clk_i   ( clk_i                  ),
    .rst_ni  ( rst_ni                 ),
    .push_i  ( dpop & ~mem_req_o.we   ),
    .data_i  ( dreq.tid               ),
    .pop_i   ( drd_pop                ),
    .data_o  ( drd_tid                ),
    .full_o  ( drd_full               ),
    .empty_o (                        )
  );

  id_fifo #(
    .dtype ( adapter_pkg::tid_t      ),
    .DEPTH ( adapter_pkg::META_DEPTH )
  ) i_dwr_fifo (
    .clk_i   ( clk_i                 ),
    .rst_ni  ( rst_ni                ),
    .push_i  ( dpop & mem_req_o.we   ),
    .data_i  ( dreq.tid              ),
    .pop_i   ( dwr_pop               ),
    .data_o  ( dwr_tid               ),
    .full_o  ( dwr_full              ),
    .empty_o (                       )
  );

  ////////////////////
  // return path

  line_assembler #(
    .NUM_WORDS ( adapter_pkg::ILINE_WORDS )
  ) i_iline (
    .clk_i  ( clk_i              ),
    .rst_ni ( rst_ni             ),
    .beat_i ( ibeat              ),
    .last_i ( mem_rd_i.last      ),
    .data_i ( mem_rd_i.data      ),
    .line_o ( iline              )
  );

  line_assembler #(
    .NUM_WORDS ( adapter_pkg::DLINE_WORDS )
  ) i_dline (
    .clk_i  ( clk_i              ),
    .rst_ni ( rst_ni             ),
    .beat_i ( dbeat              ),
    .last_i ( mem_rd_i.last      ),
    .data_i ( mem_rd_i.data      ),
    .line_o ( dline              )
  );

  rtrn_ctrl i_rtrn_ctrl (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .mem_rd_valid_i    ( mem_rd_valid_i    ),
    .mem_rd_i          ( mem_rd_i          ),
    .mem_b_valid_i     ( mem_b_valid_i     ),
    .itid_i            ( itid              ),
    .drd_tid_i         ( drd_tid           ),
    .dwr_tid_i         ( dwr_tid           ),
    .iline_i           ( iline             ),
    .dline_i           ( dline             ),
    .mem_rd_ready_o    ( mem_rd_ready_o    ),
    .mem_b_ready_o     ( mem_b_ready_o     ),
    .ibeat_o           ( ibeat             ),
    .dbeat_o           ( dbeat             ),
    .ird_pop_o         ( ird_pop           ),
    .drd_pop_o         ( drd_pop           ),
    .dwr_pop_o         ( dwr_pop           ),
    .icache_rtrn_vld_o ( icache_rtrn_vld_o ),
    .icache_rtrn_o     ( icache_rtrn_o     ),
    .dcache_rtrn_vld_o ( dcache_rtrn_vld_o ),
    .dcache_rtrn_o     ( dcache_rtrn_o     )
  );

endmodule

// ==== verilog/id_fifo.sv ====
`timescale 1ns/1ns

module id_fifo #(
  parameter type         dtype = logic,
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  dtype data_i,
  input  logic pop_i,
  output dtype data_o,
  output logic full_o,
  output logic empty_o
);

  dtype                       mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] usage_q;
  logic                       do_push, do_pop;

  assign full_o  = (usage_q == DEPTH);
  assign empty_o = (usage_q == '0);
  // pushes into a full fifo and pops from an empty one are ignored
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptr
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        usage_q <= usage_q + 1'b1;
      end else if (!do_push && do_pop) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_mem
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== verilog/line_assembler.sv ====
`timescale 1ns/1ns

module line_assembler #(
  parameter int unsigned NUM_WORDS = 2
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            beat_i,
  input  logic                                            last_i,
  input  adapter_pkg::word_t                              data_i,
  output logic [NUM_WORDS-1:0][adapter_pkg::WORD_W-1:0]   line_o
);

  logic [NUM_WORDS-1:0][adapter_pkg::WORD_W-1:0] line_d, line_q;
  adapter_pkg::blen_t                            idx;

  beat_counter i_beat_counter (
    .clk_i  ( clk_i  ),
    .rst_ni ( rst_ni ),
    .beat_i ( beat_i ),
    .last_i ( last_i ),
    .idx_o  ( idx    )
  );

  always_comb begin : p_line
    line_d = line_q;
    if (beat_i) begin
      // first beat starts a fresh line so short reads leave upper words zero
      if (idx == '0) begin
        line_d = '0;
      end
      for (int w = 0; w < NUM_WORDS; w++) begin
        if (idx == w) begin
          line_d[w] = data_i;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_reg
    if (!rst_ni) begin
      line_q <= '0;
    end else begin
      line_q <= line_d;
    end
  end

  assign line_o = line_q;

endmodule

// ==== verilog/req_arbiter.sv ====
`timescale 1ns/1ns

module req_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  adapter_pkg::icache_req_t ireq_i,
  input  logic                     ireq_empty_i,
  input  adapter_pkg::dcache_req_t dreq_i,
  input  logic                     dreq_empty_i,
  input  logic                     ird_full_i,
  input  logic                     drd_full_i,
  input  logic                     dwr_full_i,
  input  logic                     mem_gnt_i,
  output logic                     mem_req_valid_o,
  output adapter_pkg::mem_req_t    mem_req_o,
  output logic                     ipop_o,
  output logic                     dpop_o
);

  adapter_pkg::arb_state_e state_d, state_q;
  logic                    dprio_d, dprio_q;
  logic                    i_elig, d_elig;
  logic                    sel_data, take;
  logic [7:0]              store_be;

  // a side may only go out if its tid fifo has room
  assign i_elig = ~ireq_empty_i & ~ird_full_i;
  assign d_elig = ~dreq_empty_i &
                  ((dreq_i.rtype == adapter_pkg::DREQ_STORE) ? ~dwr_full_i : ~drd_full_i);

  always_comb begin : p_sel
    unique case (state_q)
      adapter_pkg::ARB_HOLD_I: sel_data = 1'b0;
      adapter_pkg::ARB_HOLD_D: sel_data = 1'b1;
      default:                 sel_data = d_elig & (dprio_q | ~i_elig);
    endcase
  end

  assign mem_req_valid_o = sel_data ? d_elig : i_elig;
  assign take            = mem_req_valid_o & mem_gnt_i;
  assign ipop_o          = take & ~sel_data;
  assign dpop_o          = take & sel_data;

  // lock onto the chosen side until memory takes it
  always_comb begin : p_fsm
    state_d = state_q;
    dprio_d = dprio_q;
    if (take) begin
      state_d = adapter_pkg::ARB_IDLE;
      dprio_d = ~sel_data;
    end else if (mem_req_valid_o) begin
      state_d = sel_data ? adapter_pkg::ARB_HOLD_D : adapter_pkg::ARB_HOLD_I;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= adapter_pkg::ARB_IDLE;
      dprio_q <= 1'b0;
    end else begin
      state_q <= state_d;
      dprio_q <= dprio_d;
    end
  end

  ////////////////////
  // request build

  always_comb begin : p_be
    unique case (dreq_i.size[1:0])
      2'd0:    store_be = 8'h01 << dreq_i.paddr[2:0];
      2'd1:    store_be = 8'h03 << {dreq_i.paddr[2:1], 1'b0};
      2'd2:    store_be = 8'h0f << {dreq_i.paddr[2], 2'b00};
      default: store_be = 8'hff;
    endcase
  end

  always_comb begin : p_req
    mem_req_o = '0;
    if (sel_data) begin
      mem_req_o.addr = dreq_i.paddr;
      mem_req_o.size = dreq_i.size[1:0];
      mem_req_o.id   = adapter_pkg::DCACHE_CHAN;
      if (dreq_i.rtype == adapter_pkg::DREQ_STORE) begin
        // single beat, full 64 bit lane
        mem_req_o.we    = 1'b1;
        mem_req_o.wdata = dreq_i.data;
        mem_req_o.be    = store_be;
      end else if (dreq_i.size[2]) begin
        mem_req_o.blen = adapter_pkg::blen_t'(adapter_pkg::DLINE_WORDS - 1);
      end
    end else begin
      mem_req_o.addr = ireq_i.paddr;
      mem_req_o.size = adapter_pkg::SIZE_WORD;
      mem_req_o.id   = adapter_pkg::ICACHE_CHAN;
      if (!ireq_i.nc) begin
        mem_req_o.blen = adapter_pkg::blen_t'(adapter_pkg::ILINE_WORDS - 1);
      end
    end
  end

endmodule

// ==== verilog/rtrn_ctrl.sv ====
`timescale 1ns/1ns

module rtrn_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          mem_rd_valid_i,
  input  adapter_pkg::mem_rd_t          mem_rd_i,
  input  logic                          mem_b_valid_i,
  input  adapter_pkg::tid_t             itid_i,
  input  adapter_pkg::tid_t             drd_tid_i,
  input  adapter_pkg::tid_t             dwr_tid_i,
  input  logic [adapter_pkg::ILINE_WORDS-1:0][adapter_pkg::WORD_W-1:0] iline_i,
  input  logic [adapter_pkg::DLINE_WORDS-1:0][adapter_pkg::WORD_W-1:0] dline_i,
  output logic                          mem_rd_ready_o,
  output logic                          mem_b_ready_o,
  output logic                          ibeat_o,
  output logic                          dbeat_o,
  output logic                          ird_pop_o,
  output logic                          drd_pop_o,
  output logic                          dwr_pop_o,
  output logic                          icache_rtrn_vld_o,
  output adapter_pkg::icache_rtrn_t     icache_rtrn_o,
  output logic                          dcache_rtrn_vld_o,
  output adapter_pkg::dcache_rtrn_t     dcache_rtrn_o
);

  logic                ivld_q, dvld_q;
  adapter_pkg::tid_t   itid_q, dtid_q;
  adapter_pkg::drtrn_e dtype_q;

  ////////////////////
  // decode

  // reads never stall
  assign mem_rd_ready_o = 1'b1;

  assign ibeat_o = mem_rd_valid_i & (mem_rd_i.id == adapter_pkg::ICACHE_CHAN);
  assign dbeat_o = mem_rd_valid_i & (mem_rd_i.id == adapter_pkg::DCACHE_CHAN);

  assign ird_pop_o = ibeat_o & mem_rd_i.last;
  assign drd_pop_o = dbeat_o & mem_rd_i.last;

  // a write response is taken only in a cycle without a read beat
  assign mem_b_ready_o = ~mem_rd_valid_i;
  assign dwr_pop_o     = mem_b_valid_i & mem_b_ready_o;

  ////////////////////
  // return regs

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rtrn
    if (!rst_ni) begin
      ivld_q  <= 1'b0;
      dvld_q  <= 1'b0;
      itid_q  <= '0;
      dtid_q  <= '0;
      dtype_q <= adapter_pkg::DRTRN_LOAD_ACK;
    end else begin
      ivld_q <= ird_pop_o;
      dvld_q <= drd_pop_o | dwr_pop_o;
      if (ird_pop_o) begin
        itid_q <= itid_i;
      end
      if (drd_pop_o) begin
        dtid_q  <= drd_tid_i;
        dtype_q <= adapter_pkg::DRTRN_LOAD_ACK;
      end else if (dwr_pop_o) begin
        dtid_q  <= dwr_tid_i;
        dtype_q <= adapter_pkg::DRTRN_STORE_ACK;
      end
    end
  end

  // line data is already registered in the assemblers
  always_comb begin : p_out
    icache_rtrn_vld_o   = ivld_q;
    icache_rtrn_o.tid   = itid_q;
    icache_rtrn_o.data  = iline_i;
    dcache_rtrn_vld_o   = dvld_q;
    dcache_rtrn_o.rtype = dtype_q;
    dcache_rtrn_o.tid   = dtid_q;
    dcache_rtrn_o.data  = dline_i;
  end

endmodule
